// File: Bender.yml
package:
  name: cog

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cog_pkg.sv
      - cog_if.sv
      - row_scan.sv
      - col_moment.sv
      - cog_divider.sv
      - cog_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - cog_chk.sv
      - tb_cog.sv

// File: cog_chk.sv
// Concurrent assertions on the center of gravity top-level ports
// Bound to cog_top

`timescale 1ns/1ps
`default_nettype none

module cog_chk (
    input wire                 CCLK,
    input wire                 RST_N,
    input wire                 vsync,
    input wire                 select_en,
    input wire                 done,
    input wire cog_pkg::addr_t vsize,
    input wire cog_pkg::addr_t addr
);

    // Result strobe
    done_one_cycle: assert property (@(posedge CCLK) disable iff (!RST_N)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // A scan only opens after a sampled vsync rise
    scan_needs_vsync: assert property (@(posedge CCLK) disable iff (!RST_N)
        $rose(select_en) |-> $past(vsync, 1) && !$past(vsync, 2))
        else $error("select_en rose without a vsync rising edge");

    addr_in_frame: assert property (@(posedge CCLK) disable iff (!RST_N)
        select_en |-> (addr < vsize))
        else $error("addr reached vsize while select_en was high");

endmodule

bind cog_top cog_chk u_chk (
    .CCLK      (CCLK),
    .RST_N     (RST_N),
    .vsync     (vsync),
    .select_en (select_en),
    .done      (done),
    .vsize     (vsize),
    .addr      (addr)
);

`default_nettype wire

// File: cog_consts.svh
// Widths and limits of the center of gravity datapath
// Sizes of rows, addresses, sums and the serial divider

`ifndef COG_CONSTS_SVH
`define COG_CONSTS_SVH

// ---------------------------------------------------------------------------
// Frame geometry
// ---------------------------------------------------------------------------

// Pixels in one memory row, one bit each
`define COG_ROW_BITS    32

// Row address and frame size
`define COG_ADDR_BITS   11

// ---------------------------------------------------------------------------
// Sums and division
// ---------------------------------------------------------------------------

// Pixel count S
`define COG_SUM_S_BITS  20

// Moment sums SX, SY and the integer quotients
`define COG_SUM_M_BITS  28

// Binary fraction below the quotient
`define COG_FRAC_BITS   20

// One divider step per numerator bit, fraction included
`define COG_DIV_STEPS   (`COG_SUM_M_BITS + `COG_FRAC_BITS)

`endif

// File: cog_divider.sv
// Dual restoring divider: SX/S and SY/S in lockstep
// Integer quotient plus binary fraction, registered with a done pulse

`timescale 1ns/1ps
`default_nettype none

`include "cog_consts.svh"

module cog_divider (
    input  wire             CCLK,
    input  wire             RST_N,
    sums_if.sink            sums,
    output logic            done,
    output cog_pkg::sum_s_t sum_s,
    output cog_pkg::sum_m_t sum_sx,
    output cog_pkg::sum_m_t sum_sy,
    output cog_pkg::sum_m_t quot_x,
    output cog_pkg::frac_t  frac_x,
    output cog_pkg::sum_m_t quot_y,
    output cog_pkg::frac_t  frac_y
);

    localparam int STEPS    = `COG_DIV_STEPS;
    localparam int FRAC     = `COG_FRAC_BITS;
    localparam int DEN_BITS = `COG_SUM_S_BITS;
    localparam int CNT_BITS = $clog2(`COG_DIV_STEPS);

    cog_pkg::div_state_t state;
    logic [CNT_BITS-1:0] step;
    logic                load;
    logic                last_step;
    cog_pkg::sum_s_t     den;
    cog_pkg::sum_m_t     cap_sx;
    cog_pkg::sum_m_t     cap_sy;

    // Index 0 is x, index 1 is y
    logic [STEPS-1:0]    num       [2];
    logic [STEPS-1:0]    num_next  [2];
    logic [DEN_BITS-1:0] rem       [2];
    logic [DEN_BITS-1:0] rem_next  [2];
    logic [DEN_BITS:0]   rem_shift [2];
    logic                fit       [2];

    assign load      = (state == cog_pkg::D_IDLE) && sums.valid;
    assign last_step = (step == CNT_BITS'(STEPS - 1));

    // One restoring step, quotient bits shift in behind the numerator
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            rem_shift[k] = {rem[k], num[k][STEPS-1]};
            fit[k]       = (rem_shift[k] >= {1'b0, den});
            rem_next[k]  = fit[k] ? DEN_BITS'(rem_shift[k] - {1'b0, den})
                                  : rem_shift[k][DEN_BITS-1:0];
            num_next[k]  = {num[k][STEPS-2:0], fit[k]};
        end
    end

    // Datapath
    always_ff @(posedge CCLK) begin
        if (load) begin
            den    <= sums.sum_s;
            cap_sx <= sums.sum_sx;
            cap_sy <= sums.sum_sy;
            num[0] <= {sums.sum_sx, {FRAC{1'b0}}};
            num[1] <= {sums.sum_sy, {FRAC{1'b0}}};
            rem[0] <= '0;
            rem[1] <= '0;
        end else if (state == cog_pkg::D_RUN) begin
            for (int k = 0; k < 2; k++) begin
                num[k] <= num_next[k];
                rem[k] <= rem_next[k];
            end
        end
    end

    // ------------------------------------------------------------------------
    // Step control and result registers
    // ------------------------------------------------------------------------
    always_ff @(posedge CCLK or negedge RST_N) begin
        if (!RST_N) begin
            state  <= cog_pkg::D_IDLE;
            step   <= '0;
            done   <= 1'b0;
            sum_s  <= '0;
            sum_sx <= '0;
            sum_sy <= '0;
            quot_x <= '0;
            frac_x <= '0;
            quot_y <= '0;
            frac_y <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                cog_pkg::D_IDLE: begin
                    if (sums.valid) begin
                        state <= cog_pkg::D_RUN;
                        step  <= '0;
                    end
                end
                cog_pkg::D_RUN: begin
                    step <= step + 1'b1;
                    if (last_step) begin
                        state  <= cog_pkg::D_IDLE;
                        done   <= 1'b1;
                        sum_s  <= den;
                        sum_sx <= cap_sx;
                        sum_sy <= cap_sy;
                        // Empty frame gives zero results
                        if (den == '0) begin
                            quot_x <= '0;
                            frac_x <= '0;
                            quot_y <= '0;
                            frac_y <= '0;
                        end else begin
                            quot_x <= num_next[0][STEPS-1:FRAC];
                            frac_x <= num_next[0][FRAC-1:0];
                            quot_y <= num_next[1][STEPS-1:FRAC];
                            frac_y <= num_next[1][FRAC-1:0];
                        end
                    end
                end
                default: state <= cog_pkg::D_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: cog_if.sv
// Stage-to-stage interfaces of the center of gravity design
// row_if carries masked rows, sums_if carries the frame sums

`timescale 1ns/1ps
`default_nettype none

// ---------------------------------------------------------------------------
// Rows from the scanner to the moment accumulator
// ---------------------------------------------------------------------------
interface row_if;

    logic           valid;
    cog_pkg::row_t  bits;
    cog_pkg::addr_t index;
    // Set with the final row of a frame
    logic           last;

    modport source (
        output valid,
        output bits,
        output index,
        output last
    );

    modport sink (
        input valid,
        input bits,
        input index,
        input last
    );

endinterface

// ---------------------------------------------------------------------------
// Frame sums from the accumulator to the divider
// ---------------------------------------------------------------------------
interface sums_if;

    logic            valid;
    cog_pkg::sum_s_t sum_s;
    cog_pkg::sum_m_t sum_sx;
    cog_pkg::sum_m_t sum_sy;

    modport source (
        output valid,
        output sum_s,
        output sum_sx,
        output sum_sy
    );

    modport sink (
        input valid,
        input sum_s,
        input sum_sx,
        input sum_sy
    );

endinterface

`default_nettype wire

// File: cog_pkg.sv
// Shared types of the center of gravity design
// Data widths as types and the FSM state enums

`default_nettype none

`include "cog_consts.svh"

package cog_pkg;

    // Data types
    typedef logic [`COG_SUM_S_BITS-1:0] sum_s_t;
    typedef logic [`COG_SUM_M_BITS-1:0] sum_m_t;
    typedef logic [`COG_FRAC_BITS-1:0]  frac_t;
    typedef logic [`COG_ROW_BITS-1:0]   row_t;
    typedef logic [`COG_ADDR_BITS-1:0]  addr_t;

    // Row scanner
    typedef enum logic [1:0] {
        S_IDLE,
        S_SCAN,
        S_DRAIN
    } scan_state_t;

    // Moment accumulator
    typedef enum logic {
        M_ACCUM,
        M_WEIGH
    } moment_state_t;

    // Serial divider
    typedef enum logic {
        D_IDLE,
        D_RUN
    } div_state_t;

endpackage

`default_nettype wire

// File: cog_top.sv
// Center of gravity top level
// Row scanner, moment accumulator and divider in a chain

`timescale 1ns/1ps
`default_nettype none

module cog_top (
    input  wire                 CCLK,
    input  wire                 RST_N,
    input  wire                 vsync,
    input  wire cog_pkg::addr_t hsize,
    input  wire cog_pkg::addr_t vsize,
    input  wire                 data_en,
    input  wire cog_pkg::row_t  memin,
    output cog_pkg::addr_t      addr,
    output logic                select_en,
    output logic                done,
    output cog_pkg::sum_s_t     sum_s,
    output cog_pkg::sum_m_t     sum_sx,
    output cog_pkg::sum_m_t     sum_sy,
    output cog_pkg::sum_m_t     quot_x,
    output cog_pkg::frac_t      frac_x,
    output cog_pkg::sum_m_t     quot_y,
    output cog_pkg::frac_t      frac_y
);

    row_if  rows ();
    sums_if sums ();

    row_scan m_row_scan (
        .CCLK      (CCLK),
        .RST_N     (RST_N),
        .vsync     (vsync),
        .hsize     (hsize),
        .vsize     (vsize),
        .data_en   (data_en),
        .memin     (memin),
        .addr      (addr),
        .select_en (select_en),
        .rows      (rows)
    );

    col_moment m_col_moment (
        .CCLK  (CCLK),
        .RST_N (RST_N),
        .hsize (hsize),
        .rows  (rows),
        .sums  (sums)
    );

    cog_divider m_cog_divider (
        .CCLK   (CCLK),
        .RST_N  (RST_N),
        .sums   (sums),
        .done   (done),
        .sum_s  (sum_s),
        .sum_sx (sum_sx),
        .sum_sy (sum_sy),
        .quot_x (quot_x),
        .frac_x (frac_x),
        .quot_y (quot_y),
        .frac_y (frac_y)
    );

endmodule

`default_nettype wire

// File: col_moment.sv
// Moment accumulator: popcount, S and SY sums, per-column counts
// and the SX weighting pass after the last row of a frame

`timescale 1ns/1ps
`default_nettype none

`include "cog_consts.svh"

module col_moment (
    input  wire                 CCLK,
    input  wire                 RST_N,
    input  wire cog_pkg::addr_t hsize,
    row_if.sink                 rows,
    sums_if.source              sums
);

    localparam int ROW_BITS = `COG_ROW_BITS;
    localparam int COL_BITS = $clog2(`COG_ROW_BITS);

    cog_pkg::moment_state_t state;
    logic [COL_BITS:0]      pop;
    logic                   frame_end;
    logic                   weigh_end;

    cog_pkg::sum_s_t acc_s;
    cog_pkg::sum_s_t next_s;
    cog_pkg::sum_s_t hold_s;
    cog_pkg::sum_m_t acc_sy;
    cog_pkg::sum_m_t next_sy;
    cog_pkg::sum_m_t hold_sy;
    cog_pkg::sum_m_t acc_sx;
    cog_pkg::sum_m_t weight;

    cog_pkg::addr_t col_cnt  [ROW_BITS];
    cog_pkg::addr_t col_next [ROW_BITS];
    cog_pkg::addr_t col_hold [ROW_BITS];
    cog_pkg::addr_t col;

    // Popcount and column counts with the incoming row
    always_comb begin
        pop = '0;
        for (int i = 0; i < ROW_BITS; i++) begin
            pop         = pop + rows.bits[i];
            col_next[i] = col_cnt[i] + rows.bits[i];
        end
    end

    assign next_s    = acc_s + pop;
    assign next_sy   = acc_sy + cog_pkg::sum_m_t'(pop) * cog_pkg::sum_m_t'(rows.index);
    assign frame_end = rows.valid && rows.last;
    assign weigh_end = (state == cog_pkg::M_WEIGH) && (col == '0);
    assign weight    = cog_pkg::sum_m_t'(col_hold[col[COL_BITS-1:0]])
                     * cog_pkg::sum_m_t'(col);

    // ------------------------------------------------------------------------
    // Row accumulation, cleared at frame end so the next frame can start
    // ------------------------------------------------------------------------
    always_ff @(posedge CCLK or negedge RST_N) begin
        if (!RST_N) begin
            acc_s  <= '0;
            acc_sy <= '0;
            for (int i = 0; i < ROW_BITS; i++) begin
                col_cnt[i] <= '0;
            end
        end else if (rows.valid) begin
            acc_s  <= rows.last ? '0 : next_s;
            acc_sy <= rows.last ? '0 : next_sy;
            for (int i = 0; i < ROW_BITS; i++) begin
                col_cnt[i] <= rows.last ? '0 : col_next[i];
            end
        end
    end

    // Snapshot of the finished frame
    always_ff @(posedge CCLK) begin
        if (frame_end) begin
            hold_s  <= next_s;
            hold_sy <= next_sy;
            for (int i = 0; i < ROW_BITS; i++) begin
                col_hold[i] <= col_next[i];
            end
        end
    end

    // ------------------------------------------------------------------------
    // SX weighting, one column per cycle from hsize-1 down to 0
    // ------------------------------------------------------------------------
    always_ff @(posedge CCLK or negedge RST_N) begin
        if (!RST_N) begin
            state      <= cog_pkg::M_ACCUM;
            col        <= '0;
            acc_sx     <= '0;
            sums.valid <= 1'b0;
        end else begin
            sums.valid <= 1'b0;
            case (state)
                cog_pkg::M_ACCUM: begin
                    if (frame_end) begin
                        state  <= cog_pkg::M_WEIGH;
                        col    <= hsize - 1'b1;
                        acc_sx <= '0;
                    end
                end
                cog_pkg::M_WEIGH: begin
                    acc_sx <= acc_sx + weight;
                    col    <= col - 1'b1;
                    if (weigh_end) begin
                        state      <= cog_pkg::M_ACCUM;
                        sums.valid <= 1'b1;
                    end
                end
                default: state <= cog_pkg::M_ACCUM;
            endcase
        end
    end

    always_ff @(posedge CCLK) begin
        if (weigh_end) begin
            sums.sum_s  <= hold_s;
            sums.sum_sy <= hold_sy;
            sums.sum_sx <= acc_sx + weight;
        end
    end

endmodule

`default_nettype wire

// File: row_scan.sv
// Row scanner: frame start on vsync, row address walk,
// row counting, column masking and forwarding on row_if

`timescale 1ns/1ps
`default_nettype none

module row_scan (
    input  wire                 CCLK,
    input  wire                 RST_N,
    input  wire                 vsync,
    input  wire cog_pkg::addr_t hsize,
    input  wire cog_pkg::addr_t vsize,
    input  wire                 data_en,
    input  wire cog_pkg::row_t  memin,
    output cog_pkg::addr_t      addr,
    output logic                select_en,
    row_if.source               rows
);

    localparam int ROW_BITS = $bits(cog_pkg::row_t);

    cog_pkg::scan_state_t state;
    logic                 vsync_d;
    logic                 vsync_rise;
    logic                 accept;
    cog_pkg::addr_t       row_cnt;
    cog_pkg::addr_t       vsize_m1;
    cog_pkg::row_t        col_mask;

    assign vsync_rise = vsync & ~vsync_d;
    assign vsize_m1   = vsize - 1'b1;
    // Rows only count while a frame is open
    assign accept     = data_en && (state != cog_pkg::S_IDLE);

    // Columns at or above hsize are cleared
    always_comb begin
        for (int i = 0; i < ROW_BITS; i++) begin
            col_mask[i] = (i < hsize);
        end
    end

    // ------------------------------------------------------------------------
    // Frame FSM and address walk
    // ------------------------------------------------------------------------
    always_ff @(posedge CCLK or negedge RST_N) begin
        if (!RST_N) begin
            state     <= cog_pkg::S_IDLE;
            vsync_d   <= 1'b0;
            select_en <= 1'b0;
            addr      <= '0;
            row_cnt   <= '0;
        end else begin
            vsync_d <= vsync;
            case (state)
                cog_pkg::S_IDLE: begin
                    if (vsync_rise) begin
                        state     <= cog_pkg::S_SCAN;
                        select_en <= 1'b1;
                        addr      <= '0;
                        row_cnt   <= '0;
                    end
                end
                cog_pkg::S_SCAN: begin
                    if (addr == vsize_m1) begin
                        state     <= cog_pkg::S_DRAIN;
                        select_en <= 1'b0;
                    end else begin
                        addr <= addr + 1'b1;
                    end
                end
                cog_pkg::S_DRAIN: begin
                    // Waiting for the remaining rows
                end
                default: begin
                    state     <= cog_pkg::S_IDLE;
                    select_en <= 1'b0;
                end
            endcase
            // Final row closes the frame
            if (accept) begin
                row_cnt <= row_cnt + 1'b1;
                if (row_cnt == vsize_m1) begin
                    state <= cog_pkg::S_IDLE;
                end
            end
        end
    end

    // Forward the row one cycle after data_en
    always_ff @(posedge CCLK or negedge RST_N) begin
        if (!RST_N) begin
            rows.valid <= 1'b0;
        end else begin
            rows.valid <= accept;
        end
    end

    always_ff @(posedge CCLK) begin
        if (accept) begin
            rows.bits  <= memin & col_mask;
            rows.index <= row_cnt;
            rows.last  <= (row_cnt == vsize_m1);
        end
    end

endmodule

`default_nettype wire

// File: tb_cog.sv
// Testbench for cog_top with clock, reset and a frame memory model
// Reference model, directed tests and watchdog

`timescale 1ns/1ps
`default_nettype none

`include "cog_consts.svh"

module tb_cog;

    localparam int PERIOD       = 4;
    localparam int FRAC         = `COG_FRAC_BITS;
    localparam int MEM_ROWS     = 1 << `COG_ADDR_BITS;
    localparam int MAX_V        = 64;
    localparam int FRAME_CYCLES = MAX_V + `COG_ROW_BITS + `COG_DIV_STEPS + 20;
    localparam int N_RANDOM     = 6;
    localparam int N_FRAMES     = N_RANDOM + 5;
    localparam int WATCHDOG_NS  = (N_FRAMES * FRAME_CYCLES + 10) * PERIOD;

    typedef struct packed {
        logic [63:0] s;
        logic [63:0] sx;
        logic [63:0] sy;
        logic [63:0] qx;
        logic [63:0] fx;
        logic [63:0] qy;
        logic [63:0] fy;
    } res_t;

    logic            CCLK;
    logic            RST_N;
    logic            vsync;
    cog_pkg::addr_t  hsize;
    cog_pkg::addr_t  vsize;
    logic            data_en;
    cog_pkg::row_t   memin;
    cog_pkg::addr_t  addr;
    logic            select_en;
    logic            done;
    cog_pkg::sum_s_t sum_s;
    cog_pkg::sum_m_t sum_sx;
    cog_pkg::sum_m_t sum_sy;
    cog_pkg::sum_m_t quot_x;
    cog_pkg::frac_t  frac_x;
    cog_pkg::sum_m_t quot_y;
    cog_pkg::frac_t  frac_y;

    cog_pkg::row_t frame_mem [0:MEM_ROWS-1];
    cog_pkg::row_t row_d1;
    cog_pkg::row_t row_d2;
    logic          sel_d1;
    logic          sel_d2;
    int            lat;
    int            addr_exp;
    integer        seed;
    int            errors;
    int            checks;

    cog_top UUT (
        .CCLK (CCLK), .RST_N (RST_N), .vsync (vsync), .hsize (hsize), .vsize (vsize),
        .data_en (data_en), .memin (memin), .addr (addr), .select_en (select_en),
        .done (done), .sum_s (sum_s), .sum_sx (sum_sx), .sum_sy (sum_sy),
        .quot_x (quot_x), .frac_x (frac_x), .quot_y (quot_y), .frac_y (frac_y)
    );

    always #(PERIOD / 2) CCLK = ~CCLK;

    // Frame memory read at request time and answered after lat cycles
    always @(posedge CCLK) begin
        sel_d1 <= select_en;
        sel_d2 <= sel_d1;
        row_d1 <= frame_mem[addr];
        row_d2 <= row_d1;
        case (lat)
            1: begin
                data_en <= select_en;
                memin   <= frame_mem[addr];
            end
            2: begin
                data_en <= sel_d1;
                memin   <= row_d1;
            end
            default: begin
                data_en <= sel_d2;
                memin   <= row_d2;
            end
        endcase
    end

    // Address walk from 0 with one row request per select_en cycle
    always @(posedge CCLK) begin
        if (select_en === 1'b1) begin
            check_value("addr", addr, addr_exp);
            addr_exp = addr_exp + 1;
        end else if (addr_exp != 0) begin
            check_value("select_en cycles", addr_exp, vsize);
            addr_exp = 0;
        end
    end

    // -------------------------------------------------------------------------
    // Checking and reference model
    // -------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_results(input res_t e, input string tag);
        check_value({tag, " sum_s"}, sum_s, e.s);
        check_value({tag, " sum_sx"}, sum_sx, e.sx);
        check_value({tag, " sum_sy"}, sum_sy, e.sy);
        check_value({tag, " quot_x"}, quot_x, e.qx);
        check_value({tag, " frac_x"}, frac_x, e.fx);
        check_value({tag, " quot_y"}, quot_y, e.qy);
        check_value({tag, " frac_y"}, frac_y, e.fy);
    endtask

    function automatic res_t reference(input int hs, input int vs);
        res_t   r;
        longint s;
        longint sx;
        longint sy;
        r  = '0;
        s  = 0;
        sx = 0;
        sy = 0;
        for (int y = 0; y < vs; y++) begin
            for (int x = 0; x < hs; x++) begin
                if (frame_mem[y][x]) begin
                    s++;
                    sx += x;
                    sy += y;
                end
            end
        end
        r.s  = s;
        r.sx = sx;
        r.sy = sy;
        // Quotient plus floor of remainder scaled by the fraction width
        if (s != 0) begin
            r.qx = sx / s;
            r.fx = ((sx % s) << FRAC) / s;
            r.qy = sy / s;
            r.fy = ((sy % s) << FRAC) / s;
        end
        return r;
    endfunction

    // -------------------------------------------------------------------------
    // Frame control
    // -------------------------------------------------------------------------
    task automatic clear_frame(input int vs);
        for (int y = 0; y < vs; y++) begin
            frame_mem[y] = '0;
        end
    endtask

    task automatic pulse_vsync();
        vsync <= 1'b1;
        @(posedge CCLK);
        vsync <= 1'b0;
    endtask

    task automatic start_frame(input int hs, input int vs);
        lat = 1 + ({$random(seed)} % 3);
        @(posedge CCLK);
        hsize <= cog_pkg::addr_t'(hs);
        vsize <= cog_pkg::addr_t'(vs);
        pulse_vsync();
    endtask

    task automatic wait_done(output bit got);
        int n;
        n   = 0;
        got = 1'b0;
        while (!got && n < 2 * FRAME_CYCLES) begin
            @(posedge CCLK);
            n++;
            got = (done === 1'b1);
        end
        if (!got) begin
            errors++;
            $display("Error at %0t ns: no done pulse within %0d cycles", $time, n);
        end
    endtask

    task automatic run_frame(input int hs, input int vs, input string tag);
        res_t e;
        bit   got;
        e = reference(hs, vs);
        start_frame(hs, vs);
        wait_done(got);
        if (got) check_results(e, tag);
    endtask

    // -------------------------------------------------------------------------
    // Directed tests
    // -------------------------------------------------------------------------
    task automatic test_empty_frame();
        res_t e;
        bit   got;
        // Junk above hsize only
        for (int y = 0; y < 16; y++) begin
            frame_mem[y] = {y[10:0], ~y[10:0], 10'h000};
        end
        e = '0;
        start_frame(8, 16);
        wait_done(got);
        if (got) check_results(e, "empty");
    endtask

    task automatic test_single_pixel();
        res_t e;
        bit   got;
        clear_frame(12);
        frame_mem[5][9] = 1'b1;
        e    = '0;
        e.s  = 1;
        e.sx = 9;
        e.sy = 5;
        e.qx = 9;
        e.qy = 5;
        start_frame(16, 12);
        wait_done(got);
        if (got) check_results(e, "single");
    endtask

    task automatic test_fixed_pattern();
        clear_frame(14);
        for (int y = 2; y <= 5; y++) frame_mem[y][7:3] = '1;
        for (int y = 8; y <= 10; y++) frame_mem[y][20:12] = '1;
        run_frame(24, 14, "fixed");
    endtask

    task automatic test_random_frames();
        int hs;
        int vs;
        for (int n = 0; n < N_RANDOM; n++) begin
            hs = 1 + ({$random(seed)} % `COG_ROW_BITS);
            vs = 1 + ({$random(seed)} % 48);
            for (int y = 0; y < vs; y++) frame_mem[y] = $random(seed);
            run_frame(hs, vs, "random");
        end
    endtask

    // Stray vsync mid scan and a second frame right after the last row
    task automatic test_overlap();
        res_t e1;
        res_t e2;
        int   k;
        int   cnt;
        bit   got;
        for (int y = 0; y < 60; y++) frame_mem[y] = $random(seed);
        e1 = reference(24, 60);
        start_frame(24, 60);
        k   = 0;
        cnt = 0;
        while (cnt < 60) begin
            @(posedge CCLK);
            k++;
            if (data_en) cnt++;
            if (k == 5) vsync <= 1'b1;
            if (k == 6) vsync <= 1'b0;
        end
        for (int y = 0; y < 60; y++) frame_mem[y] = $random(seed);
        e2 = reference(24, 60);
        pulse_vsync();
        wait_done(got);
        if (got) check_results(e1, "overlap first");
        wait_done(got);
        if (got) check_results(e2, "overlap second");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Error: watchdog expired at %0t ns before the tests finished", $time);
        $display("Checks failed");
        $finish;
    end

    initial begin
        seed     = 32'h0d9fcba1;
        errors   = 0;
        checks   = 0;
        lat      = 1;
        addr_exp = 0;
        CCLK     = 1'b0;
        RST_N    = 1'b0;
        vsync    = 1'b0;
        hsize    = 1;
        vsize    = 1;
        data_en  = 1'b0;
        memin    = '0;
        clear_frame(MEM_ROWS);
        repeat (3) @(posedge CCLK);
        RST_N <= 1'b1;
        test_empty_frame();
        test_single_pixel();
        test_fixed_pattern();
        test_random_frames();
        test_overlap();
        $display("Summary: %0d values compared, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
cog_pkg.sv
cog_if.sv
row_scan.sv
col_moment.sv
cog_divider.sv
cog_top.sv
cog_chk.sv
tb_cog.sv
